// ==== addUnit.sv ====
// Add unit
// Integer add or subtract (opcode bit 0) written straight into a small
// result queue, popped by the arbiter whenever it is not stalled

`timescale 1ns/1ps
`default_nettype none

module addUnit #(
	parameter int DEPTH = 4
) (
	input  wire                    clock,
	input  wire                    reset,
	input  wire                    en,        // Command pending for this unit
	input  wire                    stall,     // From the arbiter
	input  wire laneTypes::data_t  data1,
	input  wire laneTypes::data_t  data2,
	input  wire laneTypes::token_t token,
	output logic                   accept,    // Command written this cycle
	output logic                   valid,
	output laneTypes::result_t     result
);

	logic                        isSub;
	laneTypes::data_t            sum;
	logic                        stallReg;   // Write side stall, one cycle late
	logic                        we;
	logic                        re;
	logic [$clog2(DEPTH)-1:0]    wAddr;
	logic [$clog2(DEPTH)-1:0]    rAddr;
	logic                        full;
	logic                        empty;

	laneTypes::result_t          queue [DEPTH];

	assign isSub = token.opCode[0];
	assign sum   = isSub ? data1 - data2 : data1 + data2;   // Wraps at 32 bits

	assign we     = en & ~full & ~stallReg;
	assign re     = ~empty & ~stall;
	assign accept = we;

	// Head entry leaves on every cycle valid is high
	assign valid  = re;
	assign result = queue[rAddr];

	always_ff @(posedge clock) begin
		if (reset) begin
			stallReg <= 1'b0;
		end else begin
			stallReg <= stall;
		end
	end

	always_ff @(posedge clock) begin
		if (we) begin
			queue[wAddr] <= '{token: token, data: sum};
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// Queue pointers
	////////////////////////////////////////////////////////////////////////////

	ringBuffControl #(
		.NUM_ENTRY (DEPTH)
	) ringBuffControl_i (
		.clock (clock),
		.reset (reset),
		.we    (we),
		.re    (re),
		.wAddr (wAddr),
		.rAddr (rAddr),
		.full  (full),
		.empty (empty),
		.count ()
	);

endmodule

`default_nettype wire

// ==== compile.f ====
laneTypes.sv
ringBuffControl.sv
issueDecode.sv
addUnit.sv
mulUnit.sv
resultArbiter.sv
laneTop.sv
laneTb.sv

// ==== issueDecode.sv ====
// Issue decoder
// Takes one command at a time, stamps it with the running issue number and
// holds the enable of the target unit until that unit accepts it

`timescale 1ns/1ps
`default_nettype none

module issueDecode (
	input  wire                  clock,
	input  wire                  reset,
	input  wire                  cmdValid,
	input  wire laneTypes::command_t cmd,
	output logic                 cmdReady,
	output logic                 addEn,
	output logic                 mulEn,
	output laneTypes::data_t     data1,
	output laneTypes::data_t     data2,
	output laneTypes::token_t    token,
	input  wire                  addAccept,
	input  wire                  mulAccept
);

	logic                 pendValid;   // Slot holds a command
	laneTypes::command_t  pendCmd;
	laneTypes::issueNo_t  pendNo;
	laneTypes::issueNo_t  issueCount;  // Next number to hand out
	logic                 take;
	logic                 done;

	assign cmdReady = ~pendValid;
	assign take     = cmdValid & cmdReady;
	assign done     = (addEn & addAccept) | (mulEn & mulAccept);

	// Opcode bit 1 steers to the multiply unit
	assign addEn = pendValid & ~pendCmd.opCode[1];
	assign mulEn = pendValid &  pendCmd.opCode[1];

	assign data1 = pendCmd.data1;
	assign data2 = pendCmd.data2;
	assign token = '{opCode: pendCmd.opCode, issueNo: pendNo};

	always_ff @(posedge clock) begin
		if (reset) begin
			pendValid  <= 1'b0;
			issueCount <= '0;
		end else if (take) begin
			pendValid  <= 1'b1;
			issueCount <= issueCount + 1'b1;
		end else if (done) begin
			pendValid  <= 1'b0;
		end
	end

	always_ff @(posedge clock) begin
		if (take) begin
			pendCmd <= cmd;
			pendNo  <= issueCount;
		end
	end

	oneEnable: assert property (@(posedge clock) disable iff (reset) $onehot0({addEn, mulEn}))
		else $error("Error: addEn=%h mulEn=%h together", addEn, mulEn);

endmodule

`default_nettype wire

// ==== laneTb.sv ====
// Lane testbench
// Applies a command table to the integer lane and checks every result
// against a model of the opcode rules, matched by issue number

`timescale 1ns/1ps
`default_nettype none

module laneTb;

	localparam int NUM_ROWS     = 24;
	localparam int CLOCK_PERIOD = 8;
	localparam int STALL_HOLD   = 8;              // Cycles of back-pressure before release
	localparam int WATCH_CYCLES = NUM_ROWS * 20;

	typedef struct packed {
		laneTypes::opCode_t opCode;
		laneTypes::data_t   data1;
		laneTypes::data_t   data2;
		logic               stall;                // Hold outStall with this row
	} row_t;

	logic                clock;
	logic                reset;
	logic                cmdValid;
	laneTypes::command_t cmd;
	logic                cmdReady;
	logic                outStall;
	logic                resultValid;
	laneTypes::result_t  result;

	row_t                cmdTable [NUM_ROWS];
	laneTypes::data_t    expData [64];           // Indexed by issue number
	laneTypes::opCode_t  expOp [64];
	logic                seen [64];
	int                  issued;
	int                  resultCount;
	int                  errors;
	int                  idx;
	logic                stallSeen;
	logic                sawBackPressure;
	logic [31:0]         lcgState;

	laneTop laneTop_i (
		.clock       (clock),
		.reset       (reset),
		.cmdValid    (cmdValid),
		.cmd         (cmd),
		.cmdReady    (cmdReady),
		.outStall    (outStall),
		.resultValid (resultValid),
		.result      (result)
	);

	initial begin
		clock = 1'b0;
		forever #(CLOCK_PERIOD / 2) clock = ~clock;
	end

	////////////////////////////////////////////////////////////////////////////
	// Reference model and helpers
	////////////////////////////////////////////////////////////////////////////

	function automatic laneTypes::data_t nextRandom();
		lcgState = lcgState * 32'd1664525 + 32'd1013904223;
		return lcgState;
	endfunction

	function automatic laneTypes::data_t expectedValue(laneTypes::opCode_t op,
			laneTypes::data_t a, laneTypes::data_t b);
		logic signed [63:0] wideA;
		logic signed [63:0] wideB;
		logic signed [63:0] prod;
		wideA = {{32{a[31]}}, a};
		wideB = {{32{b[31]}}, b};
		prod  = wideA * wideB;
		case (op)
			laneTypes::ADD:   return a + b;
			laneTypes::SUB:   return a - b;
			laneTypes::MULLO: return prod[31:0];
			default:          return prod[63:32];
		endcase
	endfunction

	task automatic check(input string name, input logic [63:0] got, input logic [63:0] exp);
		if (got !== exp) begin
			errors++;
			$display("Error: %s got %h expected %h", name, got, exp);
		end
	endtask

	task automatic fillTable();
		laneTypes::data_t r;
		cmdTable[0] = '{laneTypes::ADD,   32'h0000_0001, 32'h0000_0002, 1'b0};
		cmdTable[1] = '{laneTypes::ADD,   32'hffff_ffff, 32'h0000_0001, 1'b0};  // Wraps to 0
		cmdTable[2] = '{laneTypes::SUB,   32'h0000_0000, 32'h0000_0001, 1'b0};
		cmdTable[3] = '{laneTypes::SUB,   32'h8000_0000, 32'h0000_0001, 1'b0};
		cmdTable[4] = '{laneTypes::MULLO, 32'hffff_fffd, 32'h0000_0007, 1'b0};
		cmdTable[5] = '{laneTypes::MULHI, 32'hffff_fffd, 32'h0000_0007, 1'b0};
		cmdTable[6] = '{laneTypes::MULHI, 32'h8000_0000, 32'h8000_0000, 1'b0};
		cmdTable[7] = '{laneTypes::MULLO, 32'h7fff_ffff, 32'h7fff_ffff, 1'b0};
		cmdTable[8] = '{laneTypes::MULHI, 32'h8000_0000, 32'h7fff_ffff, 1'b0};
		// Random mix, then a stalled stretch, then two plain rows
		for (int i = 9; i < NUM_ROWS; i++) begin
			r = nextRandom();
			cmdTable[i].opCode = laneTypes::opCode_t'(r[31:30]);
			cmdTable[i].data1  = nextRandom();
			cmdTable[i].data2  = nextRandom();
			cmdTable[i].stall  = (i >= 16 && i < 22);
		end
	endtask

	////////////////////////////////////////////////////////////////////////////
	// Stimulus
	////////////////////////////////////////////////////////////////////////////

	initial begin
		int waitCycles;
		reset           = 1'b1;
		cmdValid        = 1'b0;
		cmd             = '0;
		outStall        = 1'b0;
		issued          = 0;
		errors          = 0;
		sawBackPressure = 1'b0;
		lcgState        = 32'h9f54_0a02;
		fillTable();
		repeat (2) @(posedge clock);
		reset <= 1'b0;
		@(posedge clock);
		check("resultValid", resultValid, 1'b0);   // Quiet after reset
		check("cmdReady", cmdReady, 1'b1);
		for (int i = 0; i < NUM_ROWS; i++) begin
			@(posedge clock);
			expData[issued] = expectedValue(cmdTable[i].opCode, cmdTable[i].data1,
				cmdTable[i].data2);
			expOp[issued]   = cmdTable[i].opCode;
			cmdValid <= 1'b1;
			cmd      <= '{opCode: cmdTable[i].opCode, data1: cmdTable[i].data1,
				data2: cmdTable[i].data2};
			outStall <= cmdTable[i].stall;
			waitCycles = 0;
			do begin
				@(posedge clock);
				waitCycles++;
				if (!cmdReady && outStall && waitCycles == STALL_HOLD) begin
					sawBackPressure = 1'b1;
					outStall <= 1'b0;             // Let the queues drain
				end
			end while (!cmdReady);
			issued++;
			cmdValid <= 1'b0;
		end
		outStall <= 1'b0;
		while (resultCount < issued) @(posedge clock);
		repeat (10) @(posedge clock);          // Catch late duplicates
		for (int i = 0; i < issued; i++) begin
			if (!seen[i]) begin
				errors++;
				$display("Result for issue number %0d never arrived", i);
			end
		end
		if (!sawBackPressure) begin
			errors++;
			$display("cmdReady never stayed low while outStall was held");
		end
		$display("Summary: errors=%0d results=%0d issued=%0d", errors, resultCount, issued);
		if (errors == 0) begin
			$display("TESTS PASSED");
		end else begin
			$display("TESTS FAILED");
		end
		$finish;
	end

	// Result monitor
	initial begin
		resultCount = 0;
		stallSeen   = 1'b0;
		for (int i = 0; i < 64; i++) seen[i] = 1'b0;
	end

	always @(posedge clock) begin
		if (!reset) begin
			if (stallSeen) check("resultValid", resultValid, 1'b0);
			if (resultValid) begin
				idx = result.token.issueNo;
				resultCount++;
				if (idx >= issued) begin
					errors++;
					$display("Result with issue number %0d was never issued", idx);
				end else if (seen[idx]) begin
					errors++;
					$display("Result with issue number %0d arrived twice", idx);
				end else begin
					seen[idx] = 1'b1;
					check("result.token.opCode", result.token.opCode, expOp[idx]);
					check("result.data", result.data, expData[idx]);
				end
			end
		end
		stallSeen = outStall;
	end

	// Watchdog
	initial begin
		#(WATCH_CYCLES * CLOCK_PERIOD);
		$display("Watchdog expired after %0d cycles with %0d of %0d results",
			WATCH_CYCLES, resultCount, NUM_ROWS);
		$display("TESTS FAILED");
		$finish;
	end

endmodule

`default_nettype wire

// ==== laneTop.sv ====
// Integer lane top level
// Issue decoder feeding the add and multiply units, whose result queues
// are merged by the result arbiter

`timescale 1ns/1ps
`default_nettype none

module laneTop (
	input  wire                      clock,
	input  wire                      reset,
	input  wire                      cmdValid,
	input  wire laneTypes::command_t cmd,
	output logic                     cmdReady,
	input  wire                      outStall,
	output logic                     resultValid,
	output laneTypes::result_t       result
);

	logic                addEn;
	logic                mulEn;
	laneTypes::data_t    data1;
	laneTypes::data_t    data2;
	laneTypes::token_t   token;
	logic                addAccept;
	logic                mulAccept;
	logic                addValid;
	logic                mulValid;
	logic                addStall;
	logic                mulStall;
	laneTypes::result_t  addResult;
	laneTypes::result_t  mulResult;

	issueDecode issueDecode_i (
		.clock     (clock),
		.reset     (reset),
		.cmdValid  (cmdValid),
		.cmd       (cmd),
		.cmdReady  (cmdReady),
		.addEn     (addEn),
		.mulEn     (mulEn),
		.data1     (data1),
		.data2     (data2),
		.token     (token),
		.addAccept (addAccept),
		.mulAccept (mulAccept)
	);

	addUnit #(.DEPTH(laneTypes::ADD_DEPTH)) addUnit_i (
		.clock (clock), .reset (reset),
		.en (addEn), .stall (addStall),
		.data1 (data1), .data2 (data2), .token (token),
		.accept (addAccept), .valid (addValid), .result (addResult)
	);

	mulUnit #(.DEPTH(laneTypes::MUL_DEPTH)) mulUnit_i (
		.clock (clock), .reset (reset),
		.en (mulEn), .stall (mulStall),
		.data1 (data1), .data2 (data2), .token (token),
		.accept (mulAccept), .valid (mulValid), .result (mulResult)
	);

	resultArbiter resultArbiter_i (
		.clock       (clock),
		.reset       (reset),
		.addValid    (addValid),
		.addResult   (addResult),
		.mulValid    (mulValid),
		.mulResult   (mulResult),
		.outStall    (outStall),
		.addStall    (addStall),
		.mulStall    (mulStall),
		.resultValid (resultValid),
		.result      (result)
	);

endmodule

`default_nettype wire

// ==== laneTypes.sv ====
// Lane types
// Shared data, opcode, token, command and result types for the integer lane,
// plus the result queue depths used by the two execution units

`default_nettype none

package laneTypes;

	////////////////////////////////////////////////////////////////////////////
	// Words and numbering
	////////////////////////////////////////////////////////////////////////////

	typedef logic [31:0] data_t;        // Operand and result word
	typedef logic [5:0]  issueNo_t;     // Running issue number, wraps at 64

	// Bit 1 picks the multiply unit, bit 0 the variant
	typedef enum logic [1:0] {
		ADD   = 2'b00,
		SUB   = 2'b01,
		MULLO = 2'b10,
		MULHI = 2'b11
	} opCode_t;

	////////////////////////////////////////////////////////////////////////////
	// Bundles
	////////////////////////////////////////////////////////////////////////////

	// Travels with a command through a unit and out with its result
	typedef struct packed {
		opCode_t  opCode;
		issueNo_t issueNo;
	} token_t;

	// As presented on the lane input
	typedef struct packed {
		opCode_t opCode;
		data_t   data1;
		data_t   data2;
	} command_t;

	// Queue entry and lane output
	typedef struct packed {
		token_t token;
		data_t  data;
	} result_t;

	// Result queue depths
	localparam int ADD_DEPTH = 4;
	localparam int MUL_DEPTH = 4;

endpackage

`default_nettype wire

// ==== mulUnit.sv ====
// Multiply unit
// Signed 32x32 multiply, low or high half by opcode bit 0. One product
// register sits in front of the result queue

`timescale 1ns/1ps
`default_nettype none

module mulUnit #(
	parameter int DEPTH = 4
) (
	input  wire                    clock,
	input  wire                    reset,
	input  wire                    en,
	input  wire                    stall,
	input  wire laneTypes::data_t  data1,
	input  wire laneTypes::data_t  data2,
	input  wire laneTypes::token_t token,
	output logic                   accept,
	output logic                   valid,
	output laneTypes::result_t     result
);

	logic signed [63:0]          product;
	laneTypes::data_t            half;
	logic                        stageValid;
	laneTypes::result_t          stage;      // Product register
	logic                        stallReg;
	logic                        we;
	logic                        re;
	logic [$clog2(DEPTH)-1:0]    wAddr;
	logic [$clog2(DEPTH)-1:0]    rAddr;
	logic                        full;
	logic                        empty;

	laneTypes::result_t          queue [DEPTH];

	// Operands sign-extended to 64 bits before the multiply
	assign product = $signed(data1) * $signed(data2);
	assign half    = token.opCode[0] ? product[63:32] : product[31:0];

	assign we     = stageValid & ~full & ~stallReg;   // Stage drains into queue
	assign accept = en & (~stageValid | we);          // Free or moving on
	assign re     = ~empty & ~stall;

	assign valid  = re;
	assign result = queue[rAddr];

	always_ff @(posedge clock) begin
		if (reset) begin
			stallReg   <= 1'b0;
			stageValid <= 1'b0;
		end else begin
			stallReg <= stall;
			if (accept) begin
				stageValid <= 1'b1;
			end else if (we) begin
				stageValid <= 1'b0;
			end
		end
	end

	always_ff @(posedge clock) begin
		if (accept) begin
			stage <= '{token: token, data: half};
		end
		if (we) begin
			queue[wAddr] <= stage;
		end
	end

	ringBuffControl #(
		.NUM_ENTRY (DEPTH)
	) ringBuffControl_i (
		.clock (clock),
		.reset (reset),
		.we    (we),
		.re    (re),
		.wAddr (wAddr),
		.rAddr (rAddr),
		.full  (full),
		.empty (empty),
		.count ()
	);

	// Blocked stage keeps its product until the queue takes it
	stageHeld: assert property (@(posedge clock) disable iff (reset)
		stageValid && !we |=> stageValid && $stable(stage))
		else $error("Error: stage=%h overwritten while full", stage);

endmodule

`default_nettype wire

// ==== resultArbiter.sv ====
// Result arbiter
// Merges the add and multiply queues onto one registered result port.
// Add has priority, and outStall holds both units

`timescale 1ns/1ps
`default_nettype none

module resultArbiter (
	input  wire                     clock,
	input  wire                     reset,
	input  wire                     addValid,
	input  wire laneTypes::result_t addResult,
	input  wire                     mulValid,
	input  wire laneTypes::result_t mulResult,
	input  wire                     outStall,
	output logic                    addStall,
	output logic                    mulStall,
	output logic                    resultValid,
	output laneTypes::result_t      result
);

	////////////////////////////////////////////////////////////////////////////
	// Grant by stalling the loser
	////////////////////////////////////////////////////////////////////////////

	assign addStall = outStall;
	assign mulStall = outStall | addValid;   // Add head goes first

	always_ff @(posedge clock) begin
		if (reset) begin
			resultValid <= 1'b0;
		end else begin
			resultValid <= addValid | mulValid;
		end
	end

	// Payload only moves with a winner
	always_ff @(posedge clock) begin
		if (addValid) begin
			result <= addResult;
		end else if (mulValid) begin
			result <= mulResult;
		end
	end

	// Units must honour their stall on the read side
	singleWinner: assert property (@(posedge clock) disable iff (reset)
		!(addValid && mulValid))
		else $error("Error: addValid=%h mulValid=%h together", addValid, mulValid);

	quietUnderStall: assert property (@(posedge clock) disable iff (reset)
		outStall |=> !resultValid)
		else $error("Error: resultValid=%h after outStall", resultValid);

endmodule

`default_nettype wire

// ==== ringBuffControl.sv ====
// Ring buffer controller
// Write and read pointers, fill count and full/empty flags for a circular
// queue of NUM_ENTRY slots. The storage itself lives in the caller

`timescale 1ns/1ps
`default_nettype none

module ringBuffControl #(
	parameter int NUM_ENTRY = 4
) (
	input  wire                                 clock,
	input  wire                                 reset,
	input  wire                                 we,       // Push pulse
	input  wire                                 re,       // Pop pulse
	output logic [$clog2(NUM_ENTRY)-1:0]        wAddr,
	output logic [$clog2(NUM_ENTRY)-1:0]        rAddr,
	output logic                                full,
	output logic                                empty,
	output logic [$clog2(NUM_ENTRY+1)-1:0]      count     // Entries held
);

	assign full  = (count == NUM_ENTRY);
	assign empty = (count == 0);

	// Pointers wrap explicitly so depths need not be a power of two
	always_ff @(posedge clock) begin
		if (reset) begin
			wAddr <= '0;
			rAddr <= '0;
		end else begin
			if (we) begin
				wAddr <= (wAddr == NUM_ENTRY - 1) ? '0 : wAddr + 1'b1;
			end
			if (re) begin
				rAddr <= (rAddr == NUM_ENTRY - 1) ? '0 : rAddr + 1'b1;
			end
		end
	end

	always_ff @(posedge clock) begin
		if (reset) begin
			count <= '0;
		end else begin
			case ({we, re})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count;    // Idle or push and pop together
			endcase
		end
	end

	// Callers gate their pulses with these flags
	noWriteWhenFull: assert property (@(posedge clock) disable iff (reset) we |-> !full)
		else $error("Error: we=%h while full, count=%h", we, count);

	noReadWhenEmpty: assert property (@(posedge clock) disable iff (reset) re |-> !empty)
		else $error("Error: re=%h while empty, count=%h", re, count);

endmodule

`default_nettype wire

// ==== run.sh ====
#!/bin/sh
# Build and run the lane testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
	-f compile.f --top-module laneTb -o laneSim

out=$(./obj_dir/laneSim) || true
echo "$out"

if echo "$out" | grep -q "^TESTS PASSED$"; then
	exit 0
fi
exit 1
